// File: hw/ex_pkg.sv
// Shared types for the execute stage of a 32-bit MIPS-style pipeline.
// The encodings here are a contract with decode and the memory stage.
// Unaligned partial stores, mult/div and CP0 are not supported.

package ex_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  // Added to pc+4 so that a link instruction writes pc+8
  localparam logic [XLEN-1:0] LINK_OFFSET = 32'd4;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ADD, ADDU, SUB, SUBU,
    AND, OR, XOR, NOR,
    SLT, SLTU,
    SLL, SRL, SRA,
    LUI
  } alu_op_e;

  typedef enum logic [1:0] {
    RS, LINK_PC, SHAMT
  } src_a_e;

  typedef enum logic [1:0] {
    RT, SEXT_IMM, ZEXT_IMM, LINK_FOUR
  } src_b_e;

  typedef enum logic [3:0] {
    NONE, LB, LBU, LH, LHU, LW, SB, SH, SW
  } mem_op_e;

  typedef enum logic [1:0] {
    EXC_NONE, EXC_OVF, EXC_ADEL, EXC_ADES
  } exc_e;

  ////////////////////////////////////////////////////////////
  // Payloads
  ////////////////////////////////////////////////////////////

  // Instruction as handed over by decode
  typedef struct packed {
    alu_op_e           alu_op;
    src_a_e            src_a;
    src_b_e            src_b;
    mem_op_e           mem_op;
    logic [XLEN-1:0]   rs_data;
    logic [XLEN-1:0]   rt_data;
    logic [XLEN-1:0]   pc;
    logic [15:0]       imm16;
    logic [4:0]        shamt;
    logic              reg_we;
    logic [REG_AW-1:0] waddr;
  } ex_op_t;

  // Operands already selected, held in the first register
  typedef struct packed {
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
    alu_op_e           alu_op;
    mem_op_e           mem_op;
    logic [XLEN-1:0]   rt_data;
    logic [XLEN-1:0]   pc;
    logic              reg_we;
    logic [REG_AW-1:0] waddr;
  } ex_req_t;

  // Result towards the memory stage
  typedef struct packed {
    logic [XLEN-1:0]   result;
    logic [XLEN-1:0]   wdata;
    logic [3:0]        byte_en;
    mem_op_e           mem_op;
    exc_e              exc;
    logic [XLEN-1:0]   bad_vaddr;
    logic [XLEN-1:0]   pc;
    logic              reg_we;
    logic [REG_AW-1:0] waddr;
  } ex_res_t;

endpackage

// File: hw/stage_reg.sv
// One-entry valid/ready pipeline register for any payload type.
// Ready when empty or when the held entry leaves in the same cycle,
// so back-to-back transfers run at full rate. Only valid is reset.

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  logic     valid_q;
  payload_t data_q;

  // Allowin: empty, or draining this cycle
  assign in_ready  = !valid_q || out_ready;
  assign out_valid = valid_q;
  assign out_data  = data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_ready) begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready && in_valid) begin
      data_q <= in_data;
    end
  end

endmodule

// File: hw/ex_decode.sv
// Operand selection for the execute stage, purely combinational.
// Link instructions are expected to pair LINK_PC with LINK_FOUR so
// that the ALU produces pc+8. Encoding 3 of src_a selects zero.

module ex_decode import ex_pkg::*; (
  input  ex_op_t  op,
  output ex_req_t req
);

  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] sext_imm;
  logic [XLEN-1:0] zext_imm;
  logic [XLEN-1:0] shamt_ext;

  assign pc_plus4  = op.pc + XLEN'(4);
  assign sext_imm  = {{(XLEN-16){op.imm16[15]}}, op.imm16};
  assign zext_imm  = {{(XLEN-16){1'b0}}, op.imm16};
  assign shamt_ext = {{(XLEN-5){1'b0}}, op.shamt};

  // Operand a
  always_comb begin
    case (op.src_a)
      RS:      req.a = op.rs_data;
      LINK_PC: req.a = pc_plus4;
      SHAMT:   req.a = shamt_ext;
      default: req.a = '0;
    endcase
  end

  // Operand b
  always_comb begin
    case (op.src_b)
      RT:        req.b = op.rt_data;
      SEXT_IMM:  req.b = sext_imm;
      ZEXT_IMM:  req.b = zext_imm;
      LINK_FOUR: req.b = LINK_OFFSET;
      default:   req.b = op.rt_data;
    endcase
  end

  // Remaining fields go through untouched
  assign req.alu_op  = op.alu_op;
  assign req.mem_op  = op.mem_op;
  assign req.rt_data = op.rt_data;
  assign req.pc      = op.pc;
  assign req.reg_we  = op.reg_we;
  assign req.waddr   = op.waddr;

endmodule

// File: hw/ex_alu.sv
// 32-bit ALU for the execute stage, combinational.
// Shifts move b by a[4:0]. Only ADD and SUB report overflow;
// the unsigned forms wrap silently.

module ex_alu import ex_pkg::*; (
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  alu_op_e         op,
  output logic [XLEN-1:0] result,
  output logic            overflow
);

  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] diff;
  logic [4:0]      sa;
  logic            add_ovf;
  logic            sub_ovf;

  assign sum  = a + b;
  assign diff = a - b;
  assign sa   = a[4:0];

  // Same sign in, different sign out
  assign add_ovf = (a[XLEN-1] == b[XLEN-1]) && (sum[XLEN-1] != a[XLEN-1]);
  // Signs differ and the result takes the sign of b
  assign sub_ovf = (a[XLEN-1] != b[XLEN-1]) && (diff[XLEN-1] != a[XLEN-1]);

  ////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (op)
      ADD, ADDU: result = sum;
      SUB, SUBU: result = diff;
      AND:       result = a & b;
      OR:        result = a | b;
      XOR:       result = a ^ b;
      NOR:       result = ~(a | b);
      SLT:       result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      SLTU:      result = {{(XLEN-1){1'b0}}, a < b};
      SLL:       result = b << sa;
      SRL:       result = b >> sa;
      SRA:       result = $unsigned($signed(b) >>> sa);
      LUI:       result = {b[15:0], 16'h0000};
      default:   result = '0;
    endcase
  end

  always_comb begin
    case (op)
      ADD:     overflow = add_ovf;
      SUB:     overflow = sub_ovf;
      default: overflow = 1'b0;
    endcase
  end

endmodule

// File: hw/ex_result.sv
// Memory access formation and exception code for the execute stage.
// The ALU result is the effective address for loads and stores.
// Overflow wins over an address error when both would apply.
// A faulting instruction writes neither memory nor registers.

module ex_result import ex_pkg::*; (
  input  ex_req_t         req,
  input  logic [XLEN-1:0] alu_result,
  input  logic            overflow,
  output ex_res_t         res
);

  logic [1:0]      lane;
  logic            adel;
  logic            ades;
  exc_e            exc;
  logic [3:0]      store_be;
  logic [XLEN-1:0] store_data;

  assign lane = alu_result[1:0];

  ////////////////////////////////////////////////////////////
  // Alignment checks
  ////////////////////////////////////////////////////////////

  assign adel = ((req.mem_op == LH || req.mem_op == LHU) && lane[0]) ||
                ((req.mem_op == LW) && (|lane));
  assign ades = ((req.mem_op == SH) && lane[0]) ||
                ((req.mem_op == SW) && (|lane));

  always_comb begin
    if (overflow) begin
      exc = EXC_OVF;
    end else if (adel) begin
      exc = EXC_ADEL;
    end else if (ades) begin
      exc = EXC_ADES;
    end else begin
      exc = EXC_NONE;
    end
  end

  // Store lanes and lane-aligned data
  always_comb begin
    case (req.mem_op)
      SB: begin
        store_be   = 4'b0001 << lane;
        store_data = {{(XLEN-8){1'b0}}, req.rt_data[7:0]} << {lane, 3'b000};
      end
      SH: begin
        store_be   = lane[1] ? 4'b1100 : 4'b0011;
        store_data = lane[1] ? {req.rt_data[15:0], 16'h0000}
                             : {16'h0000, req.rt_data[15:0]};
      end
      SW: begin
        store_be   = 4'b1111;
        store_data = req.rt_data;
      end
      default: begin
        store_be   = 4'b0000;
        store_data = '0;
      end
    endcase
  end

  always_comb begin
    res.result    = alu_result;
    res.wdata     = store_data;
    res.byte_en   = (exc == EXC_NONE) ? store_be : 4'b0000;
    res.mem_op    = req.mem_op;
    res.exc       = exc;
    res.bad_vaddr = (exc == EXC_ADEL || exc == EXC_ADES) ? alu_result : '0;
    res.pc        = req.pc;
    res.reg_we    = req.reg_we && (exc == EXC_NONE);
    res.waddr     = req.waddr;
  end

endmodule

// File: hw/ex_unit.sv
// Execute stage top level with valid/ready on both sides.
// Two registers hold up to two instructions; order is kept.
// With out_ready high a result leaves one edge after the request
// register loads, and one instruction is accepted per cycle.

module ex_unit import ex_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  input  ex_op_t  in_op,
  output logic    in_ready,
  output logic    out_valid,
  output ex_res_t out_res,
  input  logic    out_ready
);

  ex_req_t         dec_req;
  ex_req_t         req_q;
  logic            req_valid;
  logic            res_ready;
  logic [XLEN-1:0] alu_result;
  logic            alu_ovf;
  ex_res_t         res_d;

  ex_decode u_decode (
    .op  (in_op),
    .req (dec_req)
  );

  stage_reg #(.payload_t(ex_req_t)) u_req_reg (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_data   (dec_req),
    .in_ready  (in_ready),
    .out_valid (req_valid),
    .out_data  (req_q),
    .out_ready (res_ready)
  );

  ex_alu u_alu (
    .a        (req_q.a),
    .b        (req_q.b),
    .op       (req_q.alu_op),
    .result   (alu_result),
    .overflow (alu_ovf)
  );

  ex_result u_result (
    .req        (req_q),
    .alu_result (alu_result),
    .overflow   (alu_ovf),
    .res        (res_d)
  );

  stage_reg #(.payload_t(ex_res_t)) u_res_reg (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (req_valid),
    .in_data   (res_d),
    .in_ready  (res_ready),
    .out_valid (out_valid),
    .out_data  (out_res),
    .out_ready (out_ready)
  );

endmodule

// File: test/ex_unit_chk.sv
// Output handshake properties, bound into every ex_unit instance.
// A failed property also bumps err_count, which the testbench polls.

module ex_unit_chk import ex_pkg::*; (
  input logic    clk,
  input logic    rst,
  input logic    out_valid,
  input logic    out_ready,
  input ex_res_t out_res
);

  int unsigned err_count = 0;

  // Output register comes out of reset empty
  assert property (@(posedge clk) rst |=> !out_valid)
    else begin
      $error("out_valid high right after reset");
      err_count++;
    end

  // A stalled result stays put until taken
  assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_res)))
    else begin
      $error("out_res changed or dropped while stalled");
      err_count++;
    end

  // Faulting instructions never write memory
  assert property (@(posedge clk) disable iff (rst)
    out_valid |-> (out_res.exc == EXC_NONE || out_res.byte_en == 4'b0000))
    else begin
      $error("byte_en set on a faulting instruction");
      err_count++;
    end

endmodule

bind ex_unit ex_unit_chk u_chk (
  .clk       (clk),
  .rst       (rst),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_res   (out_res)
);

// File: test/ex_unit_tb.sv
// Random instructions into ex_unit under random back-pressure, then
// a full-rate burst. Results are checked in order against a model.
// Outputs are sampled on the falling edge; inputs change on the rising.

module ex_unit_tb import ex_pkg::*;;

  localparam int          N_RANDOM = 340;
  localparam int          N_TOTAL  = 400;
  localparam int unsigned TIMEOUT  = N_TOTAL * 4 + 100;

  logic    clk;
  logic    rst;
  logic    in_valid;
  ex_op_t  in_op;
  logic    in_ready;
  logic    out_valid;
  ex_res_t out_res;
  logic    out_ready;

  ex_res_t     exp_q[$];
  int unsigned acc_q[$];
  int unsigned cycle       = 0;
  int unsigned burst_start = 32'hffff_ffff;
  int          received    = 0;
  logic        in_fire     = 1'b0;
  logic        burst       = 1'b0;
  logic        exp_ready;

  ex_unit i_ex_unit (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else fail_now($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic ex_res_t expect_res(input ex_op_t op);
    logic [31:0] opa;
    logic [31:0] opb;
    logic [31:0] bytes;
    logic [3:0]  be;
    longint      wide;
    logic        ovf;
    ex_res_t     e;
    int          k;
    case (op.src_a)
      RS:      opa = op.rs_data;
      LINK_PC: opa = op.pc + 32'd4;
      SHAMT:   opa = 32'(op.shamt);
      default: opa = 32'd0;
    endcase
    case (op.src_b)
      SEXT_IMM:  opb = 32'($signed(op.imm16));
      ZEXT_IMM:  opb = 32'(op.imm16);
      LINK_FOUR: opb = 32'd4;
      default:   opb = op.rt_data;
    endcase
    if (op.alu_op inside {SUB, SUBU}) begin
      wide = longint'($signed(opa)) - longint'($signed(opb));
    end else begin
      wide = longint'($signed(opa)) + longint'($signed(opb));
    end
    ovf = (op.alu_op inside {ADD, SUB}) && (wide != longint'($signed(wide[31:0])));
    e = '0;
    case (op.alu_op)
      AND:     e.result = opa & opb;
      OR:      e.result = opa | opb;
      XOR:     e.result = opa ^ opb;
      NOR:     e.result = ~(opa | opb);
      SLT:     e.result = ($signed(opa) < $signed(opb)) ? 32'd1 : 32'd0;
      SLTU:    e.result = (opa < opb) ? 32'd1 : 32'd0;
      SLL:     e.result = opb << opa[4:0];
      SRL:     e.result = opb >> opa[4:0];
      SRA:     e.result = 32'(longint'($signed(opb)) >>> opa[4:0]);
      LUI:     e.result = opb << 16;
      default: e.result = wide[31:0];
    endcase
    // Address error checks, overflow takes priority
    e.exc = ovf ? EXC_OVF : EXC_NONE;
    if (!ovf && (op.mem_op inside {LH, LHU}) && e.result[0]) e.exc = EXC_ADEL;
    if (!ovf && op.mem_op == LW && e.result[1:0] != 2'b00) e.exc = EXC_ADEL;
    if (!ovf && op.mem_op == SH && e.result[0]) e.exc = EXC_ADES;
    if (!ovf && op.mem_op == SW && e.result[1:0] != 2'b00) e.exc = EXC_ADES;
    // Replicate the store data, keep only the enabled lanes
    be    = 4'b0000;
    bytes = 32'd0;
    case (op.mem_op)
      SB: begin
        be    = 4'b0001 << e.result[1:0];
        bytes = {4{op.rt_data[7:0]}};
      end
      SH: begin
        be    = e.result[1] ? 4'b1100 : 4'b0011;
        bytes = {2{op.rt_data[15:0]}};
      end
      SW: begin
        be    = 4'b1111;
        bytes = op.rt_data;
      end
      default: be = 4'b0000;
    endcase
    for (k = 0; k < 4; k++) begin
      if (be[k]) e.wdata[8*k +: 8] = bytes[8*k +: 8];
    end
    e.byte_en   = (e.exc == EXC_NONE) ? be : 4'b0000;
    e.bad_vaddr = (e.exc inside {EXC_ADEL, EXC_ADES}) ? e.result : 32'd0;
    e.mem_op    = op.mem_op;
    e.pc        = op.pc;
    e.reg_we    = op.reg_we && (e.exc == EXC_NONE);
    e.waddr     = op.waddr;
    return e;
  endfunction

  function automatic ex_op_t random_op();
    ex_op_t op;
    op.alu_op  = alu_op_e'($urandom_range(0, 13));
    op.src_a   = src_a_e'($urandom_range(0, 2));
    op.src_b   = src_b_e'($urandom_range(0, 3));
    op.mem_op  = ($urandom_range(0, 2) == 0) ? mem_op_e'($urandom_range(1, 8)) : NONE;
    op.rs_data = $urandom();
    op.rt_data = $urandom();
    op.pc      = $urandom() & 32'hffff_fffc;
    op.imm16   = 16'($urandom());
    op.shamt   = 5'($urandom());
    op.reg_we  = 1'($urandom());
    op.waddr   = 5'($urandom());
    // Mostly base plus offset addressing for loads and stores
    if (op.mem_op != NONE && $urandom_range(0, 3) != 0) begin
      op.alu_op = ADDU;
      op.src_a  = RS;
      op.src_b  = SEXT_IMM;
    end
    if ($urandom_range(0, 7) == 0) begin
      op.alu_op = ADDU;
      op.src_a  = LINK_PC;
      op.src_b  = LINK_FOUR;
    end
    return op;
  endfunction

  task automatic compare_res(input ex_res_t got, input ex_res_t exp);
    check_field("result", got.result, exp.result);
    check_field("wdata", got.wdata, exp.wdata);
    check_field("byte_en", 32'(got.byte_en), 32'(exp.byte_en));
    check_field("mem_op", 32'(got.mem_op), 32'(exp.mem_op));
    check_field("exc", 32'(got.exc), 32'(exp.exc));
    check_field("bad_vaddr", got.bad_vaddr, exp.bad_vaddr);
    check_field("pc", got.pc, exp.pc);
    check_field("reg_we", 32'(got.reg_we), 32'(exp.reg_we));
    check_field("waddr", 32'(got.waddr), 32'(exp.waddr));
  endtask

  ////////////////////////////////////////////////////////////
  // Monitor and scoreboard
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    cycle++;
    if (cycle > TIMEOUT) fail_now("Timeout: not all results arrived in time");
    if (i_ex_unit.u_chk.err_count != 0) fail_now("A handshake property was violated");
    if (rst !== 1'b0) begin
      in_fire = 1'b0;
    end else begin
      // Input stalls only with both registers full and no drain
      exp_ready = !(exp_q.size() == 2 && !out_ready);
      assert (in_ready === exp_ready)
        else fail_now($sformatf("FAILED in_ready: got %h, expected %h", in_ready, exp_ready));
      in_fire = in_valid && in_ready;
      if (out_valid && out_ready) begin
        assert (exp_q.size() > 0) else fail_now("Output appeared with nothing in flight");
        compare_res(out_res, exp_q[0]);
        if (acc_q[0] >= burst_start) begin
          assert (cycle - acc_q[0] == 2)
            else fail_now($sformatf("FAILED latency: got %h, expected %h",
                                    cycle - acc_q[0], 2));
        end
        void'(exp_q.pop_front());
        void'(acc_q.pop_front());
        received++;
      end
      if (in_fire) begin
        exp_q.push_back(expect_res(in_op));
        acc_q.push_back(cycle);
      end
    end
  end

  task automatic send(input ex_op_t op);
    in_valid <= 1'b1;
    in_op    <= op;
    @(posedge clk);
    while (!in_fire) @(posedge clk);
  endtask

  initial begin
    forever begin
      @(posedge clk);
      out_ready <= burst || ($urandom_range(0, 9) < 7);
    end
  end

  initial begin
    int i;
    void'($urandom(15));
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_op     = '0;
    out_ready = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    for (i = 0; i < N_RANDOM; i++) begin
      while ($urandom_range(0, 9) >= 7) begin
        in_valid <= 1'b0;
        @(posedge clk);
      end
      send(random_op());
    end
    // Drain, then a back-to-back burst with out_ready held high
    in_valid <= 1'b0;
    burst    <= 1'b1;
    while (exp_q.size() != 0) @(posedge clk);
    burst_start = cycle + 1;
    for (i = N_RANDOM; i < N_TOTAL; i++) begin
      send(random_op());
    end
    in_valid <= 1'b0;
    while (received != N_TOTAL) @(posedge clk);
    repeat (5) @(posedge clk);
    if (received == N_TOTAL && exp_q.size() == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      fail_now("Extra or missing results at the end of the run");
    end
  end

endmodule

// File: src.f
hw/ex_pkg.sv
hw/stage_reg.sv
hw/ex_decode.sv
hw/ex_alu.sv
hw/ex_result.sv
hw/ex_unit.sv
test/ex_unit_chk.sv
test/ex_unit_tb.sv
